//--- hw/y86_pkg.sv
package y86_pkg;

    typedef logic [63:0] word_t;
    typedef logic [3:0]  reg_id_t;

    localparam int NUM_REGS = 15;

    localparam reg_id_t RRSP  = 4'h4;  // stack pointer
    localparam reg_id_t RNONE = 4'hf;  // no register

    // Y86-64 instruction codes
    typedef enum logic [3:0] {
        IHALT   = 4'h0,
        INOP    = 4'h1,
        IRRMOVQ = 4'h2,
        IIRMOVQ = 4'h3,
        IRMMOVQ = 4'h4,
        IMRMOVQ = 4'h5,
        IOPQ    = 4'h6,
        IJXX    = 4'h7,
        ICALL   = 4'h8,
        IRET    = 4'h9,
        IPUSHQ  = 4'ha,
        IPOPQ   = 4'hb
    } icode_t;

    typedef enum logic [2:0] {
        SAOK = 3'd1,
        SADR = 3'd2,
        SINS = 3'd3,
        SHLT = 3'd4
    } stat_t;

    // fields latched from fetch into the D register
    typedef struct packed {
        icode_t  icode;
        reg_id_t ra;
        reg_id_t rb;
        word_t   valp;
        stat_t   stat;
    } d_stage_t;

    localparam d_stage_t BUBBLE_D = '{
        icode: INOP,
        ra:    RNONE,
        rb:    RNONE,
        valp:  '0,
        stat:  SAOK
    };

endpackage

//--- hw/y86_if.sv
`timescale 1ns/1ps

// register file read ports
interface reg_read_if;
    import y86_pkg::*;

    reg_id_t src_a;
    reg_id_t src_b;
    word_t   rval_a;
    word_t   rval_b;

    modport reader (
        output src_a,
        output src_b,
        input  rval_a,
        input  rval_b
    );

    modport file (
        input  src_a,
        input  src_b,
        output rval_a,
        output rval_b
    );
endinterface

// destinations and values from the later stages
interface fwd_src_if;
    import y86_pkg::*;

    reg_id_t e_dste;
    word_t   e_vale;
    reg_id_t m_dstm;
    word_t   m_valm;
    reg_id_t m_dste;
    word_t   m_vale;
    reg_id_t w_dstm;
    word_t   w_valm;
    reg_id_t w_dste;
    word_t   w_vale;

    modport sink (
        input e_dste, e_vale,
        input m_dstm, m_valm, m_dste, m_vale,
        input w_dstm, w_valm, w_dste, w_vale
    );
endinterface

//--- hw/decode_reg.sv
`timescale 1ns/1ps

module decode_reg (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              bubble_i,
    input  y86_pkg::d_stage_t fetch_i,
    output y86_pkg::d_stage_t d_o
);
    import y86_pkg::*;

    d_stage_t d_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            d_q <= BUBBLE_D;
        end else if (bubble_i) begin
            d_q <= BUBBLE_D;  // inject nop
        end else if (!stall_i) begin
            d_q <= fetch_i;
        end
        // stall: hold
    end

    assign d_o = d_q;

    // pipeline control must never request both at once
    a_no_stall_and_bubble: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(stall_i && bubble_i)
    ) else $error("decode_reg: stall and bubble asserted together");

endmodule

//--- hw/reg_select.sv
`timescale 1ns/1ps

module reg_select (
    input  y86_pkg::d_stage_t d_i,
    output y86_pkg::reg_id_t  src_a_o,
    output y86_pkg::reg_id_t  src_b_o,
    output y86_pkg::reg_id_t  dst_e_o,
    output y86_pkg::reg_id_t  dst_m_o
);
    import y86_pkg::*;

    always_comb begin
        src_a_o = RNONE;
        src_b_o = RNONE;
        dst_e_o = RNONE;
        dst_m_o = RNONE;

        case (d_i.icode)
            IRRMOVQ: begin
                src_a_o = d_i.ra;
                dst_e_o = d_i.rb;
            end
            IIRMOVQ: begin
                dst_e_o = d_i.rb;
            end
            IRMMOVQ: begin
                src_a_o = d_i.ra;
                src_b_o = d_i.rb;  // base address
            end
            IMRMOVQ: begin
                src_b_o = d_i.rb;
                dst_m_o = d_i.ra;
            end
            IOPQ: begin
                src_a_o = d_i.ra;
                src_b_o = d_i.rb;
                dst_e_o = d_i.rb;
            end
            ICALL: begin
                src_b_o = RRSP;
                dst_e_o = RRSP;
            end
            IPUSHQ: begin
                src_a_o = d_i.ra;
                src_b_o = RRSP;
                dst_e_o = RRSP;
            end
            IPOPQ, IRET: begin
                // both read rsp twice, once as the pop address
                src_a_o = RRSP;
                src_b_o = RRSP;
                dst_e_o = RRSP;
                if (d_i.icode == IPOPQ) dst_m_o = d_i.ra;
            end
            default: ;  // halt, nop, jxx use no registers
        endcase
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic    clk_i,
    input  logic    rst_n_i,
    reg_read_if.file rd,
    fwd_src_if.sink  wb
);
    import y86_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // written every cycle, stall does not apply to write-back
            if (wb.w_dste != RNONE) begin
                regs[wb.w_dste] <= wb.w_vale;
            end
            // later assignment, so M wins on a shared ID
            if (wb.w_dstm != RNONE) begin
                regs[wb.w_dstm] <= wb.w_valm;
            end
        end
    end

    // index RNONE falls outside the array, forwarding masks it
    assign rd.rval_a = regs[rd.src_a];
    assign rd.rval_b = regs[rd.src_b];

    // write-back IDs come from the W register and must be clean
    a_wb_ids_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown({wb.w_dste, wb.w_dstm})
    ) else $error("reg_file: unknown write-back register ID");

endmodule

//--- hw/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
    input  y86_pkg::d_stage_t d_i,
    input  y86_pkg::reg_id_t  src_a_i,
    input  y86_pkg::reg_id_t  src_b_i,
    reg_read_if.reader        rd,
    fwd_src_if.sink           fwd,
    output y86_pkg::word_t    val_a_o,
    output y86_pkg::word_t    val_b_o
);
    import y86_pkg::*;

    assign rd.src_a = src_a_i;
    assign rd.src_b = src_b_i;

    // valA, with valP taking the slot for call and jxx
    always_comb begin
        if (d_i.icode == ICALL || d_i.icode == IJXX) begin
            val_a_o = d_i.valp;
        end else if (src_a_i == RNONE) begin
            val_a_o = '0;  // never matches a bubble's dst
        end else if (src_a_i == fwd.e_dste) begin
            val_a_o = fwd.e_vale;
        end else if (src_a_i == fwd.m_dstm) begin
            val_a_o = fwd.m_valm;
        end else if (src_a_i == fwd.m_dste) begin
            val_a_o = fwd.m_vale;
        end else if (src_a_i == fwd.w_dstm) begin
            val_a_o = fwd.w_valm;
        end else if (src_a_i == fwd.w_dste) begin
            val_a_o = fwd.w_vale;
        end else begin
            val_a_o = rd.rval_a;
        end
    end

    // valB, same priority without valP
    always_comb begin
        if (src_b_i == RNONE) begin
            val_b_o = '0;
        end else if (src_b_i == fwd.e_dste) begin
            val_b_o = fwd.e_vale;
        end else if (src_b_i == fwd.m_dstm) begin
            val_b_o = fwd.m_valm;
        end else if (src_b_i == fwd.m_dste) begin
            val_b_o = fwd.m_vale;
        end else if (src_b_i == fwd.w_dstm) begin
            val_b_o = fwd.w_valm;
        end else if (src_b_i == fwd.w_dste) begin
            val_b_o = fwd.w_vale;
        end else begin
            val_b_o = rd.rval_b;
        end
    end

endmodule

//--- hw/y86_decode.sv
`timescale 1ns/1ps

module y86_decode (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              bubble_i,

    // fetch stage
    input  y86_pkg::icode_t   f_icode_i,
    input  y86_pkg::reg_id_t  f_ra_i,
    input  y86_pkg::reg_id_t  f_rb_i,
    input  y86_pkg::word_t    f_valp_i,
    input  y86_pkg::stat_t    f_stat_i,

    // forwarding sources
    input  y86_pkg::reg_id_t  e_dste_i,
    input  y86_pkg::word_t    e_vale_i,
    input  y86_pkg::reg_id_t  m_dstm_i,
    input  y86_pkg::word_t    m_valm_i,
    input  y86_pkg::reg_id_t  m_dste_i,
    input  y86_pkg::word_t    m_vale_i,
    input  y86_pkg::reg_id_t  w_dstm_i,
    input  y86_pkg::word_t    w_valm_i,
    input  y86_pkg::reg_id_t  w_dste_i,
    input  y86_pkg::word_t    w_vale_i,

    output y86_pkg::word_t    d_vala_o,
    output y86_pkg::word_t    d_valb_o,
    output y86_pkg::reg_id_t  d_dste_o,
    output y86_pkg::reg_id_t  d_dstm_o,
    output y86_pkg::reg_id_t  d_srca_o,
    output y86_pkg::reg_id_t  d_srcb_o,
    output y86_pkg::stat_t    d_stat_o
);
    import y86_pkg::*;

    d_stage_t fetch_d;
    d_stage_t d_q;

    reg_read_if rd_if ();
    fwd_src_if  fwd_if ();

    assign fetch_d = '{
        icode: f_icode_i,
        ra:    f_ra_i,
        rb:    f_rb_i,
        valp:  f_valp_i,
        stat:  f_stat_i
    };

    assign fwd_if.e_dste = e_dste_i;
    assign fwd_if.e_vale = e_vale_i;
    assign fwd_if.m_dstm = m_dstm_i;
    assign fwd_if.m_valm = m_valm_i;
    assign fwd_if.m_dste = m_dste_i;
    assign fwd_if.m_vale = m_vale_i;
    assign fwd_if.w_dstm = w_dstm_i;
    assign fwd_if.w_valm = w_valm_i;
    assign fwd_if.w_dste = w_dste_i;
    assign fwd_if.w_vale = w_vale_i;

    decode_reg u_decode_reg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .bubble_i (bubble_i),
        .fetch_i  (fetch_d),
        .d_o      (d_q)
    );

    reg_select u_reg_select (
        .d_i     (d_q),
        .src_a_o (d_srca_o),
        .src_b_o (d_srcb_o),
        .dst_e_o (d_dste_o),
        .dst_m_o (d_dstm_o)
    );

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .rd      (rd_if.file),
        .wb      (fwd_if.sink)
    );

    operand_forward u_operand_forward (
        .d_i     (d_q),
        .src_a_i (d_srca_o),
        .src_b_i (d_srcb_o),
        .rd      (rd_if.reader),
        .fwd     (fwd_if.sink),
        .val_a_o (d_vala_o),
        .val_b_o (d_valb_o)
    );

    assign d_stat_o = d_q.stat;  // status rides along to execute

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam time HALF_PERIOD = 4ns;  // 8 ns clock

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1;  // off the edge
    end

endmodule

//--- verification/tb_y86_decode.sv
`timescale 1ns/1ps

module tb_y86_decode;
    import y86_pkg::*;

    localparam int NUM_CYCLES    = 3000;
    localparam int RESET_TIMEOUT = 20;

    logic    clk;
    logic    rst_n;
    logic    stall;
    logic    bubble;
    icode_t  f_icode;
    reg_id_t f_ra;
    reg_id_t f_rb;
    word_t   f_valp;
    stat_t   f_stat;
    reg_id_t e_dste;
    word_t   e_vale;
    reg_id_t m_dstm;
    word_t   m_valm;
    reg_id_t m_dste;
    word_t   m_vale;
    reg_id_t w_dstm;
    word_t   w_valm;
    reg_id_t w_dste;
    word_t   w_vale;

    word_t   d_vala;
    word_t   d_valb;
    reg_id_t d_dste;
    reg_id_t d_dstm;
    reg_id_t d_srca;
    reg_id_t d_srcb;
    stat_t   d_stat;

    integer   seed;
    int       waited;
    d_stage_t sd;  // shadow D register
    word_t    sregs [NUM_REGS];

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    y86_decode DUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .stall_i   (stall),
        .bubble_i  (bubble),
        .f_icode_i (f_icode),
        .f_ra_i    (f_ra),
        .f_rb_i    (f_rb),
        .f_valp_i  (f_valp),
        .f_stat_i  (f_stat),
        .e_dste_i  (e_dste),
        .e_vale_i  (e_vale),
        .m_dstm_i  (m_dstm),
        .m_valm_i  (m_valm),
        .m_dste_i  (m_dste),
        .m_vale_i  (m_vale),
        .w_dstm_i  (w_dstm),
        .w_valm_i  (w_valm),
        .w_dste_i  (w_dste),
        .w_vale_i  (w_vale),
        .d_vala_o  (d_vala),
        .d_valb_o  (d_valb),
        .d_dste_o  (d_dste),
        .d_dstm_o  (d_dstm),
        .d_srca_o  (d_srca),
        .d_srcb_o  (d_srcb),
        .d_stat_o  (d_stat)
    );

    task automatic check_word(input string name, input word_t exp_v, input word_t act_v);
        if (exp_v !== act_v) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg_id(input string name, input reg_id_t exp_v, input reg_id_t act_v);
        if (exp_v !== act_v) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "register ID mismatch");
        end
    endtask

    task automatic check_stat(input string name, input stat_t exp_v, input stat_t act_v);
        if (exp_v !== act_v) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "status mismatch");
        end
    endtask

    function automatic word_t rand_word();
        rand_word = {$random(seed), $random(seed)};
    endfunction

    // small set of IDs so sources and destinations collide often
    function automatic reg_id_t rand_reg_id();
        int r;
        r = $unsigned($random(seed)) % 8;
        case (r)
            0, 1:    rand_reg_id = RNONE;
            2:       rand_reg_id = RRSP;
            3:       rand_reg_id = 4'h0;
            4:       rand_reg_id = 4'h1;
            5:       rand_reg_id = 4'h2;
            default: rand_reg_id = reg_id_t'($random(seed));
        endcase
    endfunction

    function automatic stat_t rand_stat();
        case ($unsigned($random(seed)) % 4)
            0:       rand_stat = SAOK;
            1:       rand_stat = SADR;
            2:       rand_stat = SINS;
            default: rand_stat = SHLT;
        endcase
    endfunction

    // register roles for each instruction code
    task automatic expected_ids(input d_stage_t d, output reg_id_t sa, output reg_id_t sb,
                                output reg_id_t de, output reg_id_t dm);
        icode_t ic;
        ic = d.icode;
        sa = RNONE;
        sb = RNONE;
        de = RNONE;
        dm = RNONE;
        if (ic == IRRMOVQ || ic == IRMMOVQ || ic == IOPQ || ic == IPUSHQ) sa = d.ra;
        if (ic == IPOPQ || ic == IRET) sa = RRSP;
        if (ic == IOPQ || ic == IRMMOVQ || ic == IMRMOVQ) sb = d.rb;
        if (ic == ICALL || ic == IPUSHQ || ic == IPOPQ || ic == IRET) sb = RRSP;
        if (ic == IRRMOVQ || ic == IIRMOVQ || ic == IOPQ) de = d.rb;
        if (ic == IPUSHQ || ic == IPOPQ || ic == ICALL || ic == IRET) de = RRSP;
        if (ic == IMRMOVQ || ic == IPOPQ) dm = d.ra;
    endtask

    function automatic word_t expected_operand(input reg_id_t src);
        reg_id_t dsts [5];
        word_t   vals [5];
        dsts = '{e_dste, m_dstm, m_dste, w_dstm, w_dste};  // priority order
        vals = '{e_vale, m_valm, m_vale, w_valm, w_vale};
        if (src == RNONE) return '0;
        for (int i = 0; i < 5; i++) begin
            if (src == dsts[i]) return vals[i];
        end
        return sregs[src];
    endfunction

    task automatic update_model();
        if (!rst_n) begin
            sd = BUBBLE_D;
            for (int i = 0; i < NUM_REGS; i++) sregs[i] = '0;
        end else begin
            if (bubble) begin
                sd = BUBBLE_D;
            end else if (!stall) begin
                sd.icode = f_icode;
                sd.ra    = f_ra;
                sd.rb    = f_rb;
                sd.valp  = f_valp;
                sd.stat  = f_stat;
            end
            if (w_dste != RNONE) sregs[w_dste] = w_vale;
            if (w_dstm != RNONE) sregs[w_dstm] = w_valm;  // M write lands last
        end
    endtask

    task automatic drive_inputs(input int cyc);
        int r;
        r = $unsigned($random(seed)) % 8;
        stall   = (cyc >= 12) && (r == 0);
        bubble  = (cyc >= 12) && (r == 1);
        // first cycles sweep every instruction code
        f_icode = (cyc < 12) ? icode_t'(cyc) : icode_t'($unsigned($random(seed)) % 12);
        f_ra    = rand_reg_id();
        f_rb    = rand_reg_id();
        f_valp  = rand_word();
        f_stat  = rand_stat();
        e_dste  = rand_reg_id();
        e_vale  = rand_word();
        m_dstm  = rand_reg_id();
        m_valm  = rand_word();
        m_dste  = rand_reg_id();
        m_vale  = rand_word();
        w_dstm  = rand_reg_id();
        w_valm  = rand_word();
        w_dste  = rand_reg_id();
        w_vale  = rand_word();
    endtask

    task automatic check_outputs(input string name);
        reg_id_t sa;
        reg_id_t sb;
        reg_id_t de;
        reg_id_t dm;
        word_t   ea;
        expected_ids(sd, sa, sb, de, dm);
        ea = (sd.icode == ICALL || sd.icode == IJXX) ? sd.valp : expected_operand(sa);
        check_reg_id($sformatf("%s srcA", name), sa, d_srca);
        check_reg_id($sformatf("%s srcB", name), sb, d_srcb);
        check_reg_id($sformatf("%s dstE", name), de, d_dste);
        check_reg_id($sformatf("%s dstM", name), dm, d_dstm);
        check_word($sformatf("%s valA", name), ea, d_vala);
        check_word($sformatf("%s valB", name), expected_operand(sb), d_valb);
        check_stat($sformatf("%s stat", name), sd.stat, d_stat);
    endtask

    initial begin
        seed    = 80373;
        stall   = 1'b1;  // keep the reset value through the first edge
        bubble  = 1'b0;
        f_icode = INOP;
        f_ra    = RNONE;
        f_rb    = RNONE;
        f_valp  = '0;
        f_stat  = SAOK;
        e_dste  = RNONE;
        e_vale  = '0;
        m_dstm  = RNONE;
        m_valm  = '0;
        m_dste  = RNONE;
        m_vale  = '0;
        w_dstm  = RNONE;
        w_valm  = '0;
        w_dste  = RNONE;
        w_vale  = '0;
        sd      = BUBBLE_D;
        for (int i = 0; i < NUM_REGS; i++) sregs[i] = '0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            update_model();
            waited++;
            if (waited > RESET_TIMEOUT) begin
                $display("reset was not released within %0d cycles", RESET_TIMEOUT);
                $display("Simulation failed");
                $fatal(1, "reset timeout");
            end
        end

        // decode holds a bubble right after reset
        @(negedge clk);
        check_reg_id("reset srcA", RNONE, d_srca);
        check_reg_id("reset srcB", RNONE, d_srcb);
        check_reg_id("reset dstE", RNONE, d_dste);
        check_reg_id("reset dstM", RNONE, d_dstm);
        check_word("reset valA", '0, d_vala);
        check_word("reset valB", '0, d_valb);
        check_stat("reset stat", SAOK, d_stat);

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            update_model();
            #1;
            drive_inputs(cyc);
            @(negedge clk);  // outputs settled mid cycle
            check_outputs($sformatf("cycle %0d", cyc));
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- list.f
hw/y86_pkg.sv
hw/y86_if.sv
hw/decode_reg.sv
hw/reg_select.sv
hw/reg_file.sv
hw/operand_forward.sv
hw/y86_decode.sv
verification/tb_clock_gen.sv
verification/tb_y86_decode.sv
